// File: decode_pkg.sv
package decode_pkg;

	localparam int M_WIDTH = 32;        // pc and predicted target
	localparam int LG_PHT_SZ = 10;
	localparam int LG_PRF_ENTRIES = 6;
	localparam int IMM_W = 16;
	localparam int OP_W = 7;            // uop opcode, 70 members

	typedef logic [LG_PRF_ENTRIES-1:0] preg_t;

	// II stays at zero so a cleared uop reads as illegal
	typedef enum logic [OP_W-1:0] {
		II, NOP, MOV, MOVI,
		SLL, SRL, SRA, SLLV, SRLV, SRAV,
		ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
		MFHI, MTHI, MFLO, MTLO, MULT, MULTU, DIV, DIVU,
		MADD, MSUB, MUL, CLZ,
		JR, JALR, SYSCALL, BREAK, SYNC,
		BLTZ, BGEZ, BLTZL, BGEZL, BGEZAL, BAL, J, JAL,
		BEQ, BNE, BLEZ, BGTZ, BEQL, BNEL, BLEZL, BGTZL,
		ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		LB, LH, LWL, LW, LBU, LHU, LWR,
		SB, SH, SWL, SW, SWR
	} uop_op_t;

	// one fetched instruction with its prediction
	typedef struct packed {
		logic [31:0] insn;
		logic [M_WIDTH-1:0] pc;
		logic insn_pred;
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic [M_WIDTH-1:0] pred_target;
	} fetch_pkt_t;

	typedef struct packed {
		uop_op_t op;
		preg_t src_a;
		preg_t src_b;
		preg_t dst;
		logic src_a_valid;
		logic src_b_valid;
		logic dst_valid;
		logic hilo_src_valid;
		logic hilo_dst_valid;
		logic [IMM_W-1:0] imm;
		logic [M_WIDTH-IMM_W-1:0] jmp_imm;  // upper target bits for jumps
		logic [M_WIDTH-1:0] pc;
		logic br_pred;
		logic [LG_PHT_SZ-1:0] pht_idx;
		logic is_br;
		logic is_int;
		logic is_mem;
		logic is_store;
		logic has_delay_slot;
		logic has_nullifying_delay_slot;  // likely branches
		logic serializing_op;
		logic must_restart;
	} uop_t;

	// illegal uop with nothing valid, the start point of every decoder
	function automatic uop_t blank_uop(
		input logic [M_WIDTH-1:0] pc,
		input logic [LG_PHT_SZ-1:0] pht_idx
	);
		uop_t u;
		u = '0;
		u.op = II;
		u.pc = pc;
		u.pht_idx = pht_idx;
		return u;
	endfunction

	// zero pad a 5 bit architectural register number
	function automatic preg_t arch_reg(input logic [4:0] r);
		return {{(LG_PRF_ENTRIES-5){1'b0}}, r};
	endfunction

endpackage

// File: pipe_reg.sv
module pipe_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,
	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	logic full;
	payload_t data_q;

	// free slot, or the current entry leaves this edge
	assign in_ready = !full || out_ready;
	assign out_valid = full;
	assign out_data = data_q;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			full <= 1'b0;
		else if (in_ready)
			full <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			data_q <= in_data;  // held while stalled
	end

endmodule

// File: special_decode.sv
module special_decode (
	input decode_pkg::fetch_pkt_t pkt,
	output decode_pkg::uop_t uop,
	output logic claim
);

	logic [5:0] opcode;
	logic [5:0] funct;
	decode_pkg::preg_t rs;
	decode_pkg::preg_t rt;
	decode_pkg::preg_t rd;
	decode_pkg::preg_t shamt;
	logic wr_rd;  // result goes to rd

	assign opcode = pkt.insn[31:26];
	assign funct = pkt.insn[5:0];
	assign rs = decode_pkg::arch_reg(pkt.insn[25:21]);
	assign rt = decode_pkg::arch_reg(pkt.insn[20:16]);
	assign rd = decode_pkg::arch_reg(pkt.insn[15:11]);
	assign shamt = decode_pkg::arch_reg(pkt.insn[10:6]);
	assign claim = (opcode == 6'd0) || (opcode == 6'd28);

	always_comb
	begin
		uop = decode_pkg::blank_uop(pkt.pc, pkt.pht_idx);
		wr_rd = 1'b0;
		if (opcode == 6'd0)
		begin
			uop.is_int = 1'b1;
			case (funct)
				6'd0, 6'd2, 6'd3:
				begin
					uop.op = (funct == 6'd0) ? decode_pkg::SLL :
						(funct == 6'd2) ? decode_pkg::SRL : decode_pkg::SRA;
					uop.src_a = rt;
					uop.src_a_valid = 1'b1;
					uop.src_b = shamt;  // amount rides in the specifier, not a read
					wr_rd = 1'b1;
				end
				6'd4, 6'd6, 6'd7:
				begin
					uop.op = (funct == 6'd4) ? decode_pkg::SLLV :
						(funct == 6'd6) ? decode_pkg::SRLV : decode_pkg::SRAV;
					uop.src_a = rt;
					uop.src_a_valid = 1'b1;
					uop.src_b = rs;
					uop.src_b_valid = 1'b1;
					wr_rd = 1'b1;
				end
				6'd8, 6'd9:
				begin
					uop.op = funct[0] ? decode_pkg::JALR : decode_pkg::JR;
					uop.src_a = rs;
					uop.src_a_valid = 1'b1;
					// predicted target rides in the immediate fields
					uop.imm = pkt.pred_target[decode_pkg::IMM_W-1:0];
					uop.jmp_imm = pkt.pred_target[decode_pkg::M_WIDTH-1:decode_pkg::IMM_W];
					uop.is_br = 1'b1;
					uop.has_delay_slot = 1'b1;
					uop.dst = funct[0] ? rd : '0;
					uop.dst_valid = funct[0] && (rd != '0);  // link, jump kept
				end
				6'd12:
				begin
					uop.op = decode_pkg::SYSCALL;
					uop.src_a = decode_pkg::arch_reg(5'd7);
					uop.src_a_valid = 1'b1;
					uop.src_b = decode_pkg::arch_reg(5'd2);
					uop.src_b_valid = 1'b1;
					uop.dst = decode_pkg::arch_reg(5'd2);
					uop.dst_valid = 1'b1;
					uop.serializing_op = 1'b1;
					uop.must_restart = 1'b1;
				end
				6'd13:
				begin
					uop.op = decode_pkg::BREAK;
					uop.serializing_op = 1'b1;
				end
				6'd15:
				begin
					uop.op = decode_pkg::SYNC;
					uop.is_mem = 1'b1;
				end
				6'd16, 6'd18:
				begin
					uop.op = funct[1] ? decode_pkg::MFLO : decode_pkg::MFHI;
					uop.hilo_src_valid = 1'b1;
					wr_rd = 1'b1;
				end
				6'd17, 6'd19:
				begin
					uop.op = funct[1] ? decode_pkg::MTLO : decode_pkg::MTHI;
					uop.src_a = rs;
					uop.src_a_valid = 1'b1;
					uop.hilo_src_valid = 1'b1;  // other half kept
					uop.hilo_dst_valid = 1'b1;
				end
				6'd24, 6'd25, 6'd26, 6'd27:
				begin
					uop.op = (funct == 6'd24) ? decode_pkg::MULT :
						(funct == 6'd25) ? decode_pkg::MULTU :
						(funct == 6'd26) ? decode_pkg::DIV : decode_pkg::DIVU;
					uop.src_a = rs;
					uop.src_a_valid = 1'b1;
					uop.src_b = rt;
					uop.src_b_valid = 1'b1;
					uop.hilo_dst_valid = 1'b1;
				end
				6'd33, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39, 6'd42, 6'd43:
				begin
					uop.src_a = (funct == 6'd35) ? rs : rt;  // subu keeps rs - rt
					uop.src_a_valid = 1'b1;
					uop.src_b = (funct == 6'd35) ? rt : rs;
					uop.src_b_valid = 1'b1;
					wr_rd = 1'b1;
					case (funct)
						6'd33: uop.op = decode_pkg::ADDU;
						6'd35: uop.op = decode_pkg::SUBU;
						6'd36: uop.op = decode_pkg::AND;
						6'd37: uop.op = (rs == '0) ? decode_pkg::MOV : decode_pkg::OR;
						6'd38: uop.op = decode_pkg::XOR;
						6'd39: uop.op = decode_pkg::NOR;
						6'd42: uop.op = decode_pkg::SLT;
						default: uop.op = decode_pkg::SLTU;
					endcase
					if (uop.op == decode_pkg::MOV)
					begin
						uop.src_b = '0;
						uop.src_b_valid = 1'b0;
					end
				end
				6'd52: uop.op = decode_pkg::NOP;  // teq, no traps here
				default: uop.is_int = 1'b0;
			endcase
		end
		else if (opcode == 6'd28)
		begin
			uop.is_int = 1'b1;
			case (funct)
				6'd0, 6'd4:
				begin
					uop.op = funct[2] ? decode_pkg::MSUB : decode_pkg::MADD;
					uop.src_a = rt;
					uop.src_a_valid = 1'b1;
					uop.src_b = rs;
					uop.src_b_valid = 1'b1;
					uop.hilo_src_valid = 1'b1;  // accumulates into hi/lo
					uop.hilo_dst_valid = 1'b1;
				end
				6'd2:
				begin
					uop.op = decode_pkg::MUL;
					uop.src_a = rt;
					uop.src_a_valid = 1'b1;
					uop.src_b = rs;
					uop.src_b_valid = 1'b1;
					wr_rd = 1'b1;
				end
				6'd32:
				begin
					uop.op = decode_pkg::CLZ;
					uop.src_a = rs;
					uop.src_a_valid = 1'b1;
					wr_rd = 1'b1;
				end
				default: uop.is_int = 1'b0;
			endcase
		end
		if (wr_rd)
		begin
			uop.dst = rd;
			uop.dst_valid = (rd != '0);
			if (rd == '0)
				uop.op = decode_pkg::NOP;
		end
	end

endmodule

// File: branch_decode.sv
module branch_decode (
	input decode_pkg::fetch_pkt_t pkt,
	output decode_pkg::uop_t uop,
	output logic claim
);

	logic [5:0] opcode;
	decode_pkg::preg_t rs;
	decode_pkg::preg_t rt;

	assign opcode = pkt.insn[31:26];
	assign rs = decode_pkg::arch_reg(pkt.insn[25:21]);
	assign rt = decode_pkg::arch_reg(pkt.insn[20:16]);
	assign claim = ((opcode >= 6'd1) && (opcode <= 6'd7)) ||
		((opcode >= 6'd20) && (opcode <= 6'd23));

	always_comb
	begin
		uop = decode_pkg::blank_uop(pkt.pc, pkt.pht_idx);
		if (claim)
		begin
			// common to every branch, jumps trim below
			uop.src_a = rs;
			uop.src_a_valid = 1'b1;
			uop.imm = pkt.insn[15:0];
			uop.br_pred = pkt.insn_pred;
			uop.is_br = 1'b1;
			uop.is_int = 1'b1;
			uop.has_delay_slot = 1'b1;
			uop.has_nullifying_delay_slot = opcode[4];  // 20 to 23 are likely
			case (opcode)
				6'd1:
				begin
					case (pkt.insn[20:16])
						5'd0: uop.op = decode_pkg::BLTZ;
						5'd1: uop.op = decode_pkg::BGEZ;
						5'd2, 5'd3:
						begin
							uop.op = pkt.insn[16] ? decode_pkg::BGEZL : decode_pkg::BLTZL;
							uop.has_nullifying_delay_slot = 1'b1;
						end
						5'd17:
						begin
							uop.op = (rs == '0) ? decode_pkg::BAL : decode_pkg::BGEZAL;
							uop.dst = decode_pkg::arch_reg(5'd31);
							uop.dst_valid = 1'b1;
							if (rs != '0)
							begin
								uop.src_b = decode_pkg::arch_reg(5'd31);
								uop.src_b_valid = 1'b1;
							end
						end
						default: uop = decode_pkg::blank_uop(pkt.pc, pkt.pht_idx);
					endcase
				end
				6'd2, 6'd3:
				begin
					uop.src_a = '0;
					uop.src_a_valid = 1'b0;
					if (opcode[0])
					begin
						uop.op = decode_pkg::JAL;
						uop.jmp_imm = {{(decode_pkg::M_WIDTH-26){1'b0}}, pkt.insn[25:16]};
						uop.dst = decode_pkg::arch_reg(5'd31);
						uop.dst_valid = 1'b1;
						uop.br_pred = 1'b1;  // always taken
					end
					else
					begin
						uop.op = decode_pkg::J;
						uop.imm = '0;  // target folded at fetch
					end
				end
				6'd4, 6'd5, 6'd20, 6'd21:
				begin
					uop.op = (opcode[0] ? (opcode[4] ? decode_pkg::BNEL : decode_pkg::BNE) :
						(opcode[4] ? decode_pkg::BEQL : decode_pkg::BEQ));
					uop.src_b = rt;
					uop.src_b_valid = 1'b1;
				end
				6'd6, 6'd22: uop.op = opcode[4] ? decode_pkg::BLEZL : decode_pkg::BLEZ;
				default: uop.op = opcode[4] ? decode_pkg::BGTZL : decode_pkg::BGTZ;
			endcase
		end
	end

endmodule

// File: imm_mem_decode.sv
module imm_mem_decode (
	input decode_pkg::fetch_pkt_t pkt,
	output decode_pkg::uop_t uop,
	output logic claim
);

	logic [5:0] opcode;
	decode_pkg::preg_t rs;
	decode_pkg::preg_t rt;

	assign opcode = pkt.insn[31:26];
	assign rs = decode_pkg::arch_reg(pkt.insn[25:21]);
	assign rt = decode_pkg::arch_reg(pkt.insn[20:16]);

	always_comb
	begin
		uop = decode_pkg::blank_uop(pkt.pc, pkt.pht_idx);
		claim = 1'b1;
		case (opcode)
			6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15:
			begin
				uop.src_a = rs;
				uop.src_a_valid = 1'b1;
				uop.dst = rt;
				uop.dst_valid = (rt != '0);
				uop.imm = pkt.insn[15:0];
				uop.is_int = 1'b1;
				case (opcode)
					6'd9: uop.op = (rs == '0) ? decode_pkg::MOVI : decode_pkg::ADDIU;
					6'd10: uop.op = decode_pkg::SLTI;
					6'd11: uop.op = decode_pkg::SLTIU;
					6'd12: uop.op = decode_pkg::ANDI;
					6'd13: uop.op = decode_pkg::ORI;
					6'd14: uop.op = decode_pkg::XORI;
					default: uop.op = decode_pkg::LUI;
				endcase
				// movi and lui take only the immediate
				if ((uop.op == decode_pkg::MOVI) || (uop.op == decode_pkg::LUI))
				begin
					uop.src_a = '0;
					uop.src_a_valid = 1'b0;
				end
				if (rt == '0)
					uop.op = decode_pkg::NOP;
			end
			6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37, 6'd38, 6'd48:
			begin
				case (opcode)
					6'd32: uop.op = decode_pkg::LB;
					6'd33: uop.op = decode_pkg::LH;
					6'd34: uop.op = decode_pkg::LWL;
					6'd36: uop.op = decode_pkg::LBU;
					6'd37: uop.op = decode_pkg::LHU;
					6'd38: uop.op = decode_pkg::LWR;
					default: uop.op = decode_pkg::LW;  // ll too
				endcase
				uop.src_a = rs;
				uop.src_a_valid = 1'b1;
				uop.dst = rt;
				uop.dst_valid = (rt != '0);
				uop.imm = pkt.insn[15:0];
				uop.is_mem = 1'b1;
				// partial word loads merge with the old rt
				if ((opcode == 6'd34) || (opcode == 6'd38))
				begin
					uop.src_b = rt;
					uop.src_b_valid = 1'b1;
				end
			end
			6'd40, 6'd41, 6'd42, 6'd43, 6'd46:
			begin
				case (opcode)
					6'd40: uop.op = decode_pkg::SB;
					6'd41: uop.op = decode_pkg::SH;
					6'd42: uop.op = decode_pkg::SWL;
					6'd43: uop.op = decode_pkg::SW;
					default: uop.op = decode_pkg::SWR;
				endcase
				uop.src_a = rs;  // base
				uop.src_a_valid = 1'b1;
				uop.src_b = rt;  // store data
				uop.src_b_valid = 1'b1;
				uop.imm = pkt.insn[15:0];
				uop.is_mem = 1'b1;
				uop.is_store = 1'b1;
			end
			6'd51:
			begin
				uop.op = decode_pkg::NOP;  // pref is only a hint
				uop.is_int = 1'b1;
			end
			default: claim = 1'b0;
		endcase
	end

endmodule

// File: mips32_decoder.sv
module mips32_decoder (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	output logic in_ready,
	input logic [31:0] insn,
	input logic [decode_pkg::M_WIDTH-1:0] pc,
	input logic insn_pred,
	input logic [decode_pkg::LG_PHT_SZ-1:0] pht_idx,
	input logic [decode_pkg::M_WIDTH-1:0] pred_target,
	output logic out_valid,
	input logic out_ready,
	output decode_pkg::uop_t uop
);

	decode_pkg::fetch_pkt_t in_pkt;
	decode_pkg::fetch_pkt_t dec_pkt;
	logic dec_valid;   // registered packet present
	logic dec_ready;
	decode_pkg::uop_t special_uop;
	decode_pkg::uop_t branch_uop;
	decode_pkg::uop_t imm_mem_uop;
	decode_pkg::uop_t dec_uop;
	logic special_claim;
	logic branch_claim;
	logic imm_mem_claim;

	assign in_pkt = '{insn: insn, pc: pc, insn_pred: insn_pred,
		pht_idx: pht_idx, pred_target: pred_target};

	pipe_reg #(.payload_t(decode_pkg::fetch_pkt_t)) in_reg (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_data(in_pkt),
		.out_valid(dec_valid), .out_ready(dec_ready), .out_data(dec_pkt)
	);

	special_decode special_decode_inst (.pkt(dec_pkt), .uop(special_uop), .claim(special_claim));
	branch_decode branch_decode_inst (.pkt(dec_pkt), .uop(branch_uop), .claim(branch_claim));
	imm_mem_decode imm_mem_decode_inst (.pkt(dec_pkt), .uop(imm_mem_uop), .claim(imm_mem_claim));

	// claims are disjoint, nobody claiming means illegal
	always_comb
	begin
		dec_uop = decode_pkg::blank_uop(dec_pkt.pc, dec_pkt.pht_idx);
		if (special_claim)
			dec_uop = special_uop;
		else if (branch_claim)
			dec_uop = branch_uop;
		else if (imm_mem_claim)
			dec_uop = imm_mem_uop;
	end

	pipe_reg #(.payload_t(decode_pkg::uop_t)) out_reg (
		.clk(clk), .arst_n(arst_n),
		.in_valid(dec_valid), .in_ready(dec_ready), .in_data(dec_uop),
		.out_valid(out_valid), .out_ready(out_ready), .out_data(uop)
	);

endmodule

// File: clk_gen.sv
module clk_gen #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;  // 50% duty
	end

endmodule

// File: decoder_props.sv
module decoder_props (
	input logic clk,
	input logic arst_n,
	input logic out_valid,
	input logic out_ready,
	input decode_pkg::uop_t uop,
	input logic dec_valid,
	input logic special_claim,
	input logic branch_claim,
	input logic imm_mem_claim
);

	int unsigned fail_count = 0;

	out_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
	else
	begin
		$error("out_valid high while reset is held");
		fail_count++;
	end

	// stalled output keeps its uop
	out_held_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(uop))
	else
	begin
		$error("out_valid or uop changed while out_ready was low");
		fail_count++;
	end

	one_claim: assert property (@(posedge clk) disable iff (!arst_n)
		dec_valid |-> $onehot0({special_claim, branch_claim, imm_mem_claim}))
	else
	begin
		$error("more than one decoder claimed the same instruction");
		fail_count++;
	end

endmodule

bind mips32_decoder decoder_props props_inst (
	.clk(clk), .arst_n(arst_n),
	.out_valid(out_valid), .out_ready(out_ready), .uop(uop),
	.dec_valid(dec_valid), .special_claim(special_claim),
	.branch_claim(branch_claim), .imm_mem_claim(imm_mem_claim)
);

// File: decoder_tb.sv
module decoder_tb;

	localparam int N_VEC = 24;
	localparam int N_FIELDS = 13;     // columns per golden line
	localparam int TIMEOUT = 200;     // cycles per wait

	logic clk;
	logic arst_n;
	logic in_valid;
	logic in_ready;
	logic [31:0] insn;
	logic [decode_pkg::M_WIDTH-1:0] pc;
	logic insn_pred;
	logic [decode_pkg::LG_PHT_SZ-1:0] pht_idx;
	logic [decode_pkg::M_WIDTH-1:0] pred_target;
	logic out_valid;
	logic out_ready;
	decode_pkg::uop_t uop;

	logic [47:0] golden [0:N_VEC*N_FIELDS-1];
	int cycle = 0;
	int errors;
	int tests_run;
	int tests_failed;
	logic timed_out;
	logic stall_mode;
	int accept_q[$];                  // cycle of each accepted instruction

	clk_gen #(.PERIOD(20)) clk_gen_inst (.clk(clk));

	mips32_decoder mips32_decoder_inst (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_ready(in_ready),
		.insn(insn), .pc(pc), .insn_pred(insn_pred),
		.pht_idx(pht_idx), .pred_target(pred_target),
		.out_valid(out_valid), .out_ready(out_ready), .uop(uop)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	// consumer side, random back pressure in the second pass
	initial
	begin
		void'($urandom(50));
		out_ready <= 1'b0;
		forever
		begin
			@(posedge clk);
			out_ready <= stall_mode ? (($urandom % 3) != 0) : 1'b1;
		end
	end

	task automatic check_op(input string name, input decode_pkg::uop_op_t got,
		input decode_pkg::uop_op_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s got %s (0x%0h) expected %s (0x%0h)",
				$time, name, got.name(), got, exp.name(), exp);
		end
	endtask

	task automatic check_reg(input string name, input decode_pkg::preg_t got,
		input decode_pkg::preg_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_imm(input string name, input logic [decode_pkg::IMM_W-1:0] got,
		input logic [decode_pkg::IMM_W-1:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_pc(input string name, input logic [decode_pkg::M_WIDTH-1:0] got,
		input logic [decode_pkg::M_WIDTH-1:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_pht(input string name, input logic [decode_pkg::LG_PHT_SZ-1:0] got,
		input logic [decode_pkg::LG_PHT_SZ-1:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// valid and flag columns hold one 0/1 hex digit per bit, msb digit first
	task automatic compare_uop(input int idx, input decode_pkg::uop_t got);
		int b;
		logic [47:0] vb;
		logic [47:0] fl;
		b = idx * N_FIELDS;
		vb = golden[b + 11];
		fl = golden[b + 12];
		check_op("op", got.op, decode_pkg::uop_op_t'(golden[b + 5][decode_pkg::OP_W-1:0]));
		check_reg("src_a", got.src_a, golden[b + 6][decode_pkg::LG_PRF_ENTRIES-1:0]);
		check_reg("src_b", got.src_b, golden[b + 7][decode_pkg::LG_PRF_ENTRIES-1:0]);
		check_reg("dst", got.dst, golden[b + 8][decode_pkg::LG_PRF_ENTRIES-1:0]);
		check_imm("imm", got.imm, golden[b + 9][decode_pkg::IMM_W-1:0]);
		check_imm("jmp_imm", got.jmp_imm, golden[b + 10][decode_pkg::IMM_W-1:0]);
		check_pc("pc", got.pc, golden[b + 1][decode_pkg::M_WIDTH-1:0]);
		check_pht("pht_idx", got.pht_idx, golden[b + 3][decode_pkg::LG_PHT_SZ-1:0]);
		check_flag("src_a_valid", got.src_a_valid, vb[16]);
		check_flag("src_b_valid", got.src_b_valid, vb[12]);
		check_flag("dst_valid", got.dst_valid, vb[8]);
		check_flag("hilo_src_valid", got.hilo_src_valid, vb[4]);
		check_flag("hilo_dst_valid", got.hilo_dst_valid, vb[0]);
		check_flag("is_br", got.is_br, fl[32]);
		check_flag("is_int", got.is_int, fl[28]);
		check_flag("is_mem", got.is_mem, fl[24]);
		check_flag("is_store", got.is_store, fl[20]);
		check_flag("has_delay_slot", got.has_delay_slot, fl[16]);
		check_flag("has_nullifying_delay_slot", got.has_nullifying_delay_slot, fl[12]);
		check_flag("serializing_op", got.serializing_op, fl[8]);
		check_flag("must_restart", got.must_restart, fl[4]);
		check_flag("br_pred", got.br_pred, fl[0]);
	endtask

	task automatic drive_vectors();
		int i;
		int b;
		int waited;
		for (i = 0; i < N_VEC && !timed_out; i++)
		begin
			b = i * N_FIELDS;
			in_valid <= 1'b1;
			insn <= golden[b][31:0];
			pc <= golden[b + 1][decode_pkg::M_WIDTH-1:0];
			insn_pred <= golden[b + 2][0];
			pht_idx <= golden[b + 3][decode_pkg::LG_PHT_SZ-1:0];
			pred_target <= golden[b + 4][decode_pkg::M_WIDTH-1:0];
			waited = 0;
			@(posedge clk);
			while (!in_ready && waited < TIMEOUT)
			begin
				waited++;
				@(posedge clk);
			end
			if (in_ready)
				accept_q.push_back(cycle);  // transfer on this edge
			else
			begin
				$display("timeout: the DUT never accepted vector %0d", i);
				timed_out = 1'b1;
			end
		end
		in_valid <= 1'b0;
	endtask

	task automatic watch_outputs(input int pass_no, input logic check_latency);
		int i;
		int waited;
		int errs_before;
		int accepted;
		decode_pkg::uop_t got;
		for (i = 0; i < N_VEC && !timed_out; i++)
		begin
			waited = 0;
			@(posedge clk);
			while (!(out_valid && out_ready) && waited < TIMEOUT)
			begin
				waited++;
				@(posedge clk);
			end
			if (!(out_valid && out_ready))
			begin
				$display("timeout: no uop left the DUT for vector %0d", i);
				timed_out = 1'b1;
			end
			else
			begin
				got = uop;
				errs_before = errors;
				compare_uop(i, got);
				if (accept_q.size() == 0)
				begin
					errors++;
					$display("uop for vector %0d came out before any instruction was accepted", i);
				end
				else
				begin
					accepted = accept_q.pop_front();
					if (check_latency && (cycle != accepted + 2))
					begin
						errors++;
						$display("** Error at %0t: latency got %0d expected 2",
							$time, cycle - accepted);
					end
				end
				tests_run++;
				if (errors != errs_before)
					tests_failed++;
				$display("pass %0d vector %0d %s: %s", pass_no, i, got.op.name(),
					(errors == errs_before) ? "passed" : "failed");
			end
		end
	endtask

	task automatic run_pass(input int pass_no);
		int k;
		stall_mode <= (pass_no > 1);
		fork
			drive_vectors();
			watch_outputs(pass_no, pass_no == 1);  // latency only holds without stalls
		join
		// nothing may follow the last vector
		for (k = 0; k < 4 && !timed_out; k++)
		begin
			@(posedge clk);
			if (out_valid)
			begin
				errors++;
				$display("an extra uop left the DUT after the last vector of pass %0d", pass_no);
			end
		end
	endtask

	initial
	begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		stall_mode = 1'b0;
		arst_n <= 1'b0;
		in_valid <= 1'b0;
		insn <= '0;
		pc <= '0;
		insn_pred <= 1'b0;
		pht_idx <= '0;
		pred_target <= '0;
		$readmemh("decode_golden.txt", golden);
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		run_pass(1);
		if (!timed_out)
			run_pass(2);
		$display("vectors %0d, failed %0d, value errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, mips32_decoder_inst.props_inst.fail_count);
		if (errors == 0 && !timed_out && tests_run == 2 * N_VEC &&
			mips32_decoder_inst.props_inst.fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: decode_golden.txt
// insn pc pred pht target | op src_a src_b dst imm jmp_imm | valid a b d hi_rd hi_wr | flags
// flags: br int mem store delay nullify serial restart br_pred, one 0/1 digit per bit
00221821 00400000 0 000 00400100 0a 02 01 03 0000 0000 11100 010000000
00a62023 00400004 0 001 00400100 0b 05 06 04 0000 0000 11100 010000000
00094100 00400008 0 002 00400100 04 09 04 08 0000 0000 10100 010000000
018b5007 0040000c 0 003 00400100 09 0b 0c 0a 0000 0000 11100 010000000
00220021 00400010 0 004 00400100 01 02 01 00 0000 0000 11000 010000000
00053825 00400014 0 005 00400100 02 05 00 07 0000 0000 10100 010000000
00640018 00400018 0 006 00400100 16 03 04 00 0000 0000 11001 010000000
00004810 0040001c 0 007 00400100 12 00 00 09 0000 0000 00110 010000000
0000000c 00400020 0 008 00400100 20 07 02 02 0000 0000 11100 010000110
70641002 00400024 0 009 00400100 1c 04 03 02 0000 0000 11100 010000000
03e00008 00400028 0 00a 00401234 1e 1f 00 00 1234 0040 10000 110010000
24c51234 0040002c 0 00b 00400100 33 06 00 05 1234 0000 10100 010000000
2404fffe 00400030 0 00c 00400100 03 00 00 04 fffe 0000 00100 010000000
346000ff 00400034 0 00d 00400100 01 03 00 00 00ff 0000 10000 010000000
3c08abcd 00400038 0 00e 00400100 39 00 00 08 abcd 0000 00100 010000000
10220010 0040003c 1 00f 00400100 2b 01 02 00 0010 0000 11000 110010001
5464fff0 00400040 0 010 00400100 30 03 04 00 fff0 0000 11000 110011000
04110008 00400044 1 011 00400100 28 00 00 1f 0008 0000 10100 110010001
0c100040 00400048 0 012 00400100 2a 00 00 1f 0040 0010 00100 110010001
8fa20008 0040004c 1 013 00400100 3d 1d 00 02 0008 0000 10100 001000000
c0830000 00400050 0 014 00400100 3d 04 00 03 0000 0000 10100 001000000
acc5fffc 00400054 0 015 00400100 44 06 05 00 fffc 0000 11000 001100000
89070001 00400058 0 016 00400100 3c 08 07 07 0001 0000 11100 001000000
44821000 0040005c 1 017 00400100 00 00 00 00 0000 0000 00000 000000000

// File: sources.f
decode_pkg.sv
pipe_reg.sv
special_decode.sv
branch_decode.sv
imm_mem_decode.sv
mips32_decoder.sv
clk_gen.sv
decoder_props.sv
decoder_tb.sv

// File: Makefile
VERILATOR = verilator
SIM_FLAGS = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP = decoder_tb
FILE_LIST = sources.f
OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
